//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = tb_sched
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
verilog/sched_pkg.sv
verilog/sched_if.sv
verilog/sched_decode.sv
verilog/sched_execute.sv
verilog/sched_result.sv
verilog/sched_top.sv
test/tb_sched.sv

//--- include/sched_config.svh
// Build-time sizes for the issue scheduler
// ROB depth, scan window, unit counts and the flow-control ordering option

`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// ====================
// Reorder buffer
// ====================

// Number of ROB entries, a power of two keeps the index wrap cheap
`define SCHED_ROB_ENTRIES 16

// Entries examined each cycle, counted from the head
`define SCHED_WINDOW_SIZE 8

// ====================
// Functional units
// ====================

// Setting this to 1 removes ALU1 from arbitration
`define SCHED_NALU 2
`define SCHED_NAGEN 2

// With 1, flow-control ops no longer wait for older unfinished flow control
`define SCHED_OOO_FC 0

`endif

//--- test/tb_sched.sv
// Directed testbench for the issue scheduler
// Clock and reset, LCG for sequence numbers and slots, typed check tasks
// One task per scenario covering reset, ALU pair, blocked entries, sync, flow control
// and mixed traffic

`include "sched_config.svh"

module tb_sched;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 5;
	localparam int RESET_CYCLES = 5;
	localparam int QUIET_TIMEOUT = 20;
	localparam logic [31:0] LCG_SEED = 32'h7ff5_841d;
	localparam int K_ALU = 1;
	localparam int K_FC = 2;
	localparam int K_MEM = 4;
	localparam sched_pkg::unit_grant_t NO_GRANT = '0;

	// DUT inputs
	logic clk;
	logic rst;
	logic alu0_idle;
	logic alu1_idle;
	logic fcu_idle;
	logic agen0_idle;
	logic agen1_idle;
	sched_pkg::rob_ndx_t head;
	sched_pkg::rob_entry_t [`SCHED_ROB_ENTRIES-1:0] rob;
	sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_in;

	// DUT outputs with the grants regrouped into the package type
	wire sched_pkg::unit_grant_t alu0_got;
	wire sched_pkg::unit_grant_t alu1_got;
	wire sched_pkg::unit_grant_t fcu_got;
	wire sched_pkg::unit_grant_t agen0_got;
	wire sched_pkg::unit_grant_t agen1_got;
	wire sched_pkg::rob_bitmask_t alu_issue;
	wire sched_pkg::rob_bitmask_t fcu_issue;
	wire sched_pkg::rob_bitmask_t agen_issue;
	wire sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_out;

	// Slots expected on the output are built from islot_in and the grants of a scenario
	sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_exp;
	sched_pkg::seq_num_t base_sn;
	logic [31:0] lcg_state;
	int errors;
	int checks;
	bit timed_out;

	// ====================
	// Clock and DUT
	// ====================

	always #CLK_HALF clk = ~clk;

	sched_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.alu0_idle_i  (alu0_idle),
		.alu1_idle_i  (alu1_idle),
		.fcu_idle_i   (fcu_idle),
		.agen0_idle_i (agen0_idle),
		.agen1_idle_i (agen1_idle),
		.head_i       (head),
		.rob_i        (rob),
		.islot_i      (islot_in),
		.alu0_ndx_o   (alu0_got.ndx),
		.alu0_v_o     (alu0_got.v),
		.alu1_ndx_o   (alu1_got.ndx),
		.alu1_v_o     (alu1_got.v),
		.fcu_ndx_o    (fcu_got.ndx),
		.fcu_v_o      (fcu_got.v),
		.agen0_ndx_o  (agen0_got.ndx),
		.agen0_v_o    (agen0_got.v),
		.agen1_ndx_o  (agen1_got.ndx),
		.agen1_v_o    (agen1_got.v),
		.alu_issue_o  (alu_issue),
		.fcu_issue_o  (fcu_issue),
		.agen_issue_o (agen_issue),
		.islot_o      (islot_out)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ROB index of the entry pos places behind the head
	function automatic int at(input int pos);
		return (int'(head) + pos) % `SCHED_ROB_ENTRIES;
	endfunction

	// A valid entry with every operand present and an age that follows its window position
	function automatic sched_pkg::rob_entry_t make_entry(input int pos, input int kind);
		sched_pkg::rob_entry_t e;
		e = '0;
		e.v = 1'b1;
		e.sn = base_sn + sched_pkg::seq_num_t'(pos);
		e.arg_a_v = 1'b1;
		e.arg_b_v = 1'b1;
		e.arg_c_v = 1'b1;
		e.is_alu = (kind & K_ALU) != 0;
		e.is_fc = (kind & K_FC) != 0;
		e.is_mem = (kind & K_MEM) != 0;
		return e;
	endfunction

	function automatic sched_pkg::unit_grant_t grant_to(input int ndx);
		return {1'b1, sched_pkg::rob_ndx_t'(ndx)};
	endfunction

	function automatic sched_pkg::rob_bitmask_t entry_bit(input int ndx);
		return sched_pkg::rob_bitmask_t'(1) << ndx;
	endfunction

	// Outputs are only read on the falling edge half a clock after they change
	task automatic step_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
		@(negedge clk);
	endtask

	// Empty the ROB and wait until the outputs have been quiet for two clocks
	task automatic settle();
		int quiet;
		quiet = 0;
		rob = '0;
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} = '0;
		for (int i = 0; i < QUIET_TIMEOUT && quiet < 2; i++) begin
			@(negedge clk);
			if (!(alu0_got.v | alu1_got.v | fcu_got.v | agen0_got.v | agen1_got.v) &&
				(alu_issue | fcu_issue | agen_issue) == '0)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 2) begin
			$display("Timeout: grants still active %0d clocks after the ROB was emptied",
				QUIET_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	// Set a new head with a random sequence base and random incoming slots
	task automatic start_scenario(input int new_head);
		settle();
		head = sched_pkg::rob_ndx_t'(new_head);
		base_sn = sched_pkg::seq_num_t'(lcg_next() % 32);
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++)
			islot_in[i] = sched_pkg::islot_t'(lcg_next() >> 30);
		islot_exp = islot_in;
	endtask

	// ====================
	// Checks
	// ====================

	task automatic check_grant(input string what, input sched_pkg::unit_grant_t got,
		input sched_pkg::unit_grant_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s grant v=%0b ndx=%0d, expected v=%0b ndx=%0d",
				$time, what, got.v, got.ndx, exp.v, exp.ndx);
		end
	endtask

	task automatic check_mask(input string what, input sched_pkg::rob_bitmask_t got,
		input sched_pkg::rob_bitmask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s mask %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_islot(input int ndx, input sched_pkg::islot_t got,
		input sched_pkg::islot_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: islot[%0d] is %0d, expected %0d", $time, ndx, got, exp);
		end
	endtask

	task automatic check_grants(input sched_pkg::unit_grant_t a0, a1, fc, g0, g1);
		check_grant("ALU0", alu0_got, a0);
		check_grant("ALU1", alu1_got, a1);
		check_grant("FCU", fcu_got, fc);
		check_grant("AGEN0", agen0_got, g0);
		check_grant("AGEN1", agen1_got, g1);
	endtask

	task automatic check_masks(input sched_pkg::rob_bitmask_t alu, fc, mem);
		check_mask("ALU issue", alu_issue, alu);
		check_mask("FCU issue", fcu_issue, fc);
		check_mask("AGEN issue", agen_issue, mem);
	endtask

	task automatic check_islots();
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++)
			check_islot(i, islot_out[i], islot_exp[i]);
	endtask

	// ====================
	// Scenarios
	// ====================

	task automatic test_reset_values();
		islot_exp = '0;
		check_grants(NO_GRANT, NO_GRANT, NO_GRANT, NO_GRANT, NO_GRANT);
		check_masks('0, '0, '0);
		check_islots();
	endtask

	task automatic test_alu_pair();
		// Window wraps past the last ROB entry
		start_scenario(14);
		if (timed_out)
			return;
		rob[at(0)] = make_entry(0, K_ALU);
		rob[at(1)] = make_entry(1, K_ALU);
		rob[at(2)] = make_entry(2, K_ALU);
		{alu0_idle, alu1_idle} = 2'b11;
		islot_exp[at(0)] = 2'd0;
		islot_exp[at(1)] = 2'd1;
		step_cycles(2);
		check_grants(grant_to(at(0)), grant_to(at(1)), NO_GRANT, NO_GRANT, NO_GRANT);
		check_masks(entry_bit(at(0)) | entry_bit(at(1)), '0, '0);
		check_islots();

		// The second ALU0-only op must be passed over by ALU1
		start_scenario(3);
		if (timed_out)
			return;
		rob[at(0)] = make_entry(0, K_ALU);
		rob[at(0)].alu0_only = 1'b1;
		rob[at(1)] = make_entry(1, K_ALU);
		rob[at(1)].alu0_only = 1'b1;
		rob[at(2)] = make_entry(2, K_ALU);
		{alu0_idle, alu1_idle} = 2'b11;
		islot_exp[at(0)] = 2'd0;
		islot_exp[at(2)] = 2'd1;
		step_cycles(2);
		check_grants(grant_to(at(0)), grant_to(at(2)), NO_GRANT, NO_GRANT, NO_GRANT);
		check_masks(entry_bit(at(0)) | entry_bit(at(2)), '0, '0);
		check_islots();
	endtask

	task automatic test_blocked();
		start_scenario(0);
		if (timed_out)
			return;
		for (int p = 0; p < 4; p++)
			rob[at(p)] = make_entry(p, K_ALU);
		rob[at(0)].arg_a_v = 1'b0;
		rob[at(1)].arg_b_v = 1'b0;
		rob[at(2)].done = 2'b01;
		rob[at(3)].out = 2'b01;
		// Ready flow-control op held back by a busy FCU
		rob[at(4)] = make_entry(4, K_FC);
		// Memory ops do not need operand C
		rob[at(5)] = make_entry(5, K_MEM);
		rob[at(5)].arg_c_v = 1'b0;
		rob[at(6)] = make_entry(6, K_MEM);
		rob[at(6)].arg_c_v = 1'b0;
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} = 5'b11011;
		islot_exp[at(5)] = 2'd0;
		islot_exp[at(6)] = 2'd1;
		step_cycles(2);
		check_grants(NO_GRANT, NO_GRANT, NO_GRANT, grant_to(at(5)), grant_to(at(6)));
		check_masks('0, '0, entry_bit(at(5)) | entry_bit(at(6)));
		check_islots();

		// Once the FCU goes idle the waiting op is granted on the next clock
		rob[at(5)].out = 2'b01;
		rob[at(6)].out = 2'b01;
		fcu_idle = 1'b1;
		step_cycles(1);
		check_grant("FCU", fcu_got, grant_to(at(4)));
	endtask

	task automatic test_sync();
		start_scenario(5);
		if (timed_out)
			return;
		rob[at(0)] = make_entry(0, K_ALU);
		rob[at(1)] = make_entry(1, 0);
		rob[at(1)].is_sync = 1'b1;
		rob[at(2)] = make_entry(2, K_ALU);
		// Later in the window but older than the sync so it still issues
		rob[at(3)] = make_entry(0, K_MEM);
		rob[at(4)] = make_entry(4, K_FC);
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} = '1;
		islot_exp[at(0)] = 2'd0;
		islot_exp[at(3)] = 2'd0;
		step_cycles(2);
		check_grants(grant_to(at(0)), NO_GRANT, NO_GRANT, grant_to(at(3)), NO_GRANT);
		check_masks(entry_bit(at(0)), '0, entry_bit(at(3)));
		check_islots();
	endtask

	task automatic test_fc_order();
		start_scenario(9);
		if (timed_out)
			return;
		rob[at(0)] = make_entry(0, K_FC);
		rob[at(1)] = make_entry(1, K_FC);
		fcu_idle = 1'b1;
		step_cycles(2);
		check_grants(NO_GRANT, NO_GRANT, grant_to(at(0)), NO_GRANT, NO_GRANT);
		check_masks('0, entry_bit(at(0)), '0);

		// While the older op is in flight the younger one keeps waiting on an idle FCU
		rob[at(0)].out = 2'b10;
		step_cycles(2);
		check_grants(NO_GRANT, NO_GRANT, NO_GRANT, NO_GRANT, NO_GRANT);
		check_masks('0, '0, '0);

		// Older op finishes its flow-control phase and releases the younger one
		rob[at(0)].done = 2'b10;
		step_cycles(2);
		check_grants(NO_GRANT, NO_GRANT, grant_to(at(1)), NO_GRANT, NO_GRANT);
		check_masks('0, entry_bit(at(1)), '0);
	endtask

	task automatic test_mixed();
		start_scenario(10);
		if (timed_out)
			return;
		rob[at(0)] = make_entry(0, K_ALU);
		rob[at(1)] = make_entry(1, K_MEM);
		rob[at(2)] = make_entry(2, K_FC);
		rob[at(3)] = make_entry(3, K_ALU);
		rob[at(4)] = make_entry(4, K_MEM);
		rob[at(5)] = make_entry(5, K_ALU);
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} = '1;
		islot_exp[at(0)] = 2'd0;
		islot_exp[at(3)] = 2'd1;
		islot_exp[at(1)] = 2'd0;
		islot_exp[at(4)] = 2'd1;
		step_cycles(2);
		check_grants(grant_to(at(0)), grant_to(at(3)), grant_to(at(2)), grant_to(at(1)),
			grant_to(at(4)));
		check_masks(entry_bit(at(0)) | entry_bit(at(3)), entry_bit(at(2)),
			entry_bit(at(1)) | entry_bit(at(4)));
		check_islots();

		// Granted entries are now in flight and only the last ALU op is left
		rob[at(0)].out = 2'b01;
		rob[at(1)].out = 2'b01;
		rob[at(2)].out = 2'b10;
		rob[at(3)].out = 2'b01;
		rob[at(4)].out = 2'b01;
		islot_exp = islot_in;
		islot_exp[at(5)] = 2'd0;
		step_cycles(2);
		check_grants(grant_to(at(5)), NO_GRANT, NO_GRANT, NO_GRANT, NO_GRANT);
		check_masks(entry_bit(at(5)), '0, '0);
		check_islots();
	endtask

	task automatic run_tests();
		test_reset_values();
		test_alu_pair();
		test_blocked();
		test_sync();
		test_fc_order();
		test_mixed();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} = '0;
		head = '0;
		rob = '0;
		islot_in = '0;
		islot_exp = '0;
		base_sn = '0;
		lcg_state = LCG_SEED;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		run_tests();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/sched_decode.sv
// Readiness stage of the issue scheduler
// Per-entry operand, sync and flow-control checks, class masks and window order
// All results are registered

`include "sched_config.svh"

module sched_decode (
	input logic clk,
	input logic rst,
	input sched_pkg::rob_entry_t [`SCHED_ROB_ENTRIES-1:0] rob_i,
	input sched_pkg::rob_ndx_t head_i,
	sched_ready_if.decode rdy,
	sched_grant_if.decode gnt
);

	// Operand A and B present and C present unless the op is a memory access
	sched_pkg::rob_bitmask_t ops_ok;
	// An older valid sync instruction exists
	sched_pkg::rob_bitmask_t prior_sync;
	// An older flow-control op has not finished its flow-control phase
	sched_pkg::rob_bitmask_t prior_fc;
	// Conditions common to every class
	sched_pkg::rob_bitmask_t base_ok;

	sched_pkg::rob_bitmask_t alu_rdy_d;
	sched_pkg::rob_bitmask_t alu1_ok_d;
	sched_pkg::rob_bitmask_t fc_rdy_d;
	sched_pkg::rob_bitmask_t mem_rdy_d;
	sched_pkg::rob_ndx_t [`SCHED_WINDOW_SIZE-1:0] window_d;

	// ====================
	// Per-entry scans
	// ====================

	// Each entry is compared against all others once, so the logic grows with
	// the square of the ROB depth but stays a flat compare tree
	always_comb begin
		for (int g = 0; g < `SCHED_ROB_ENTRIES; g++) begin
			ops_ok[g] = rob_i[g].arg_a_v && rob_i[g].arg_b_v &&
				(rob_i[g].arg_c_v || rob_i[g].is_mem);
			prior_sync[g] = 1'b0;
			prior_fc[g] = 1'b0;
			for (int n = 0; n < `SCHED_ROB_ENTRIES; n++) begin
				if (rob_i[n].v && rob_i[n].sn < rob_i[g].sn) begin
					if (rob_i[n].is_sync)
						prior_sync[g] = 1'b1;
					if (rob_i[n].is_fc && !rob_i[n].done[1])
						prior_fc[g] = 1'b1;
				end
			end
		end
	end

	// ====================
	// Class masks
	// ====================

	always_comb begin
		for (int g = 0; g < `SCHED_ROB_ENTRIES; g++) begin
			// An entry just issued is held back one cycle so it is not picked twice
			base_ok[g] = rob_i[g].v && !(&rob_i[g].done) && ops_ok[g] &&
				!prior_sync[g] && !gnt.issued_mask[g];
			alu_rdy_d[g] = base_ok[g] && rob_i[g].is_alu && !rob_i[g].done[0] &&
				!rob_i[g].out[0];
			alu1_ok_d[g] = rob_i[g].is_alu && !rob_i[g].alu0_only;
			mem_rdy_d[g] = base_ok[g] && rob_i[g].is_mem && !rob_i[g].done[0] &&
				!rob_i[g].out[0];
			// In-order flow control waits on every older unfinished one
			fc_rdy_d[g] = base_ok[g] && rob_i[g].is_fc && !rob_i[g].done[1] &&
				!rob_i[g].out[1] && (`SCHED_OOO_FC != 0 || !prior_fc[g]);
		end
	end

	// Window order wraps at the end of the ROB
	always_comb begin
		for (int w = 0; w < `SCHED_WINDOW_SIZE; w++)
			window_d[w] = sched_pkg::rob_ndx_t'((int'(head_i) + w) % `SCHED_ROB_ENTRIES);
	end

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			rdy.alu_rdy <= '0;
			rdy.alu1_ok <= '0;
			rdy.fc_rdy <= '0;
			rdy.mem_rdy <= '0;
		end else begin
			rdy.alu_rdy <= alu_rdy_d;
			rdy.alu1_ok <= alu1_ok_d;
			rdy.fc_rdy <= fc_rdy_d;
			rdy.mem_rdy <= mem_rdy_d;
		end
	end

	// Window order follows the head one clock later
	always_ff @(posedge clk) begin
		rdy.window <= window_d;
	end

endmodule

//--- verilog/sched_execute.sv
// Arbitration stage of the issue scheduler
// Walks the window oldest first and picks entries for ALU0/1, FCU and AGEN0/1
// Produces next-cycle grants, issue masks and rewritten issue slots

`include "sched_config.svh"

module sched_execute (
	input logic alu0_idle_i,
	input logic alu1_idle_i,
	input logic fcu_idle_i,
	input logic agen0_idle_i,
	input logic agen1_idle_i,
	input sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_i,
	sched_ready_if.execute rdy,
	sched_grant_if.execute gnt
);

	// Entry under consideration in the current window position
	sched_pkg::rob_ndx_t ndx;

	// Set once a unit has been given an entry this cycle
	logic alu0_taken;
	logic alu1_taken;
	logic fcu_taken;
	logic agen0_taken;
	logic agen1_taken;

	always_comb begin
		alu0_taken = 1'b0;
		alu1_taken = 1'b0;
		fcu_taken = 1'b0;
		agen0_taken = 1'b0;
		agen1_taken = 1'b0;
		gnt.alu0_g = '0;
		gnt.alu1_g = '0;
		gnt.fcu_g = '0;
		gnt.agen0_g = '0;
		gnt.agen1_g = '0;
		gnt.alu_iss = '0;
		gnt.fc_iss = '0;
		gnt.mem_iss = '0;
		// Slots of entries that get no ALU or AGEN grant keep their value
		gnt.islot = islot_i;
		ndx = '0;

		for (int w = 0; w < `SCHED_WINDOW_SIZE; w++) begin
			ndx = rdy.window[w];

			// ====================
			// ALU pair
			// ====================

			// ALU0 gets first pick, ALU1 only sees entries ALU0 passed over
			if (alu0_idle_i && !alu0_taken && rdy.alu_rdy[ndx]) begin
				alu0_taken = 1'b1;
				gnt.alu0_g.v = 1'b1;
				gnt.alu0_g.ndx = ndx;
				gnt.alu_iss[ndx] = 1'b1;
				gnt.islot[ndx] = 2'd0;
			end else if (`SCHED_NALU > 1 && alu1_idle_i && !alu1_taken &&
				rdy.alu_rdy[ndx] && rdy.alu1_ok[ndx]) begin
				// An ALU0-only op never lands here
				alu1_taken = 1'b1;
				gnt.alu1_g.v = 1'b1;
				gnt.alu1_g.ndx = ndx;
				gnt.alu_iss[ndx] = 1'b1;
				gnt.islot[ndx] = 2'd1;
			end

			// ====================
			// Flow control
			// ====================

			// Ordering between flow-control ops is already folded into fc_rdy
			if (fcu_idle_i && !fcu_taken && rdy.fc_rdy[ndx]) begin
				fcu_taken = 1'b1;
				gnt.fcu_g.v = 1'b1;
				gnt.fcu_g.ndx = ndx;
				gnt.fc_iss[ndx] = 1'b1;
			end

			// ====================
			// Address generators
			// ====================

			if (agen0_idle_i && !agen0_taken && rdy.mem_rdy[ndx]) begin
				agen0_taken = 1'b1;
				gnt.agen0_g.v = 1'b1;
				gnt.agen0_g.ndx = ndx;
				gnt.mem_iss[ndx] = 1'b1;
				gnt.islot[ndx] = 2'd0;
			end else if (`SCHED_NAGEN > 1 && agen1_idle_i && !agen1_taken &&
				rdy.mem_rdy[ndx]) begin
				agen1_taken = 1'b1;
				gnt.agen1_g.v = 1'b1;
				gnt.agen1_g.ndx = ndx;
				gnt.mem_iss[ndx] = 1'b1;
				gnt.islot[ndx] = 2'd1;
			end
		end
	end

endmodule

//--- verilog/sched_if.sv
// Internal interfaces of the issue scheduler
// sched_ready_if carries window order and readiness masks from decode to execute
// sched_grant_if carries grants, issue masks and slots to the output stage

`include "sched_config.svh"

// ====================
// Readiness
// ====================

interface sched_ready_if;

	// ROB indices in program order, element 0 is the head
	sched_pkg::rob_ndx_t [`SCHED_WINDOW_SIZE-1:0] window;

	// Entries that could go to an ALU this cycle
	sched_pkg::rob_bitmask_t alu_rdy;
	// Entries that ALU1 may also take, cleared for ALU0-only ops
	sched_pkg::rob_bitmask_t alu1_ok;
	sched_pkg::rob_bitmask_t fc_rdy;
	sched_pkg::rob_bitmask_t mem_rdy;

	modport decode (output window, output alu_rdy, output alu1_ok, output fc_rdy,
		output mem_rdy);
	modport execute (input window, input alu_rdy, input alu1_ok, input fc_rdy,
		input mem_rdy);

endinterface

// ====================
// Grants
// ====================

interface sched_grant_if;

	// Next-cycle grants, one per unit
	sched_pkg::unit_grant_t alu0_g;
	sched_pkg::unit_grant_t alu1_g;
	sched_pkg::unit_grant_t fcu_g;
	sched_pkg::unit_grant_t agen0_g;
	sched_pkg::unit_grant_t agen1_g;

	// Next-cycle issue masks per class
	sched_pkg::rob_bitmask_t alu_iss;
	sched_pkg::rob_bitmask_t fc_iss;
	sched_pkg::rob_bitmask_t mem_iss;

	// Slot per entry, rewritten where an ALU or AGEN grant was made
	sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot;

	// Entries issued in the last registered cycle, fed back to decode
	sched_pkg::rob_bitmask_t issued_mask;

	modport execute (output alu0_g, output alu1_g, output fcu_g, output agen0_g,
		output agen1_g, output alu_iss, output fc_iss, output mem_iss, output islot);
	modport result (input alu0_g, input alu1_g, input fcu_g, input agen0_g,
		input agen1_g, input alu_iss, input fc_iss, input mem_iss, input islot,
		output issued_mask);
	modport decode (input issued_mask);

endinterface

//--- verilog/sched_pkg.sv
// Shared types for the issue scheduler
// ROB index, bit mask, sequence number, issue slot, ROB entry and unit grant

`include "sched_config.svh"

package sched_pkg;

	// ====================
	// Scalar types
	// ====================

	// Position of an entry in the ROB
	typedef logic [$clog2(`SCHED_ROB_ENTRIES)-1:0] rob_ndx_t;

	// One flag per ROB entry
	typedef logic [`SCHED_ROB_ENTRIES-1:0] rob_bitmask_t;

	// Program order tag, a smaller value is an older instruction
	typedef logic [5:0] seq_num_t;

	// Which unit of a pair took the entry, 0 for the first and 1 for the second
	typedef logic [1:0] islot_t;

	// ====================
	// Records
	// ====================

	// State of one ROB entry as the scheduler sees it
	// Bit 0 of done and out is the execute phase, bit 1 the flow-control phase
	typedef struct packed {
		logic v;
		seq_num_t sn;
		logic [1:0] done;
		logic [1:0] out;
		logic arg_a_v;
		logic arg_b_v;
		logic arg_c_v;
		logic is_alu;
		logic alu0_only;
		logic is_fc;
		logic is_mem;
		logic is_sync;
	} rob_entry_t;

	// A grant to one unit, valid for a single cycle
	typedef struct packed {
		logic v;
		rob_ndx_t ndx;
	} unit_grant_t;

endpackage

//--- verilog/sched_result.sv
// Output stage of the issue scheduler
// Registers the unit grants, class issue masks and issue slots
// Returns the union of the issue masks to the readiness stage

`include "sched_config.svh"

module sched_result (
	input logic clk,
	input logic rst,
	sched_grant_if.result gnt,
	output sched_pkg::rob_ndx_t alu0_ndx_o,
	output logic alu0_v_o,
	output sched_pkg::rob_ndx_t alu1_ndx_o,
	output logic alu1_v_o,
	output sched_pkg::rob_ndx_t fcu_ndx_o,
	output logic fcu_v_o,
	output sched_pkg::rob_ndx_t agen0_ndx_o,
	output logic agen0_v_o,
	output sched_pkg::rob_ndx_t agen1_ndx_o,
	output logic agen1_v_o,
	output sched_pkg::rob_bitmask_t alu_issue_o,
	output sched_pkg::rob_bitmask_t fcu_issue_o,
	output sched_pkg::rob_bitmask_t agen_issue_o,
	output sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_o
);

	sched_pkg::unit_grant_t alu0_q;
	sched_pkg::unit_grant_t alu1_q;
	sched_pkg::unit_grant_t fcu_q;
	sched_pkg::unit_grant_t agen0_q;
	sched_pkg::unit_grant_t agen1_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_q <= '0;
			alu1_q <= '0;
			fcu_q <= '0;
			agen0_q <= '0;
			agen1_q <= '0;
			alu_issue_o <= '0;
			fcu_issue_o <= '0;
			agen_issue_o <= '0;
			islot_o <= '0;
		end else begin
			alu0_q <= gnt.alu0_g;
			alu1_q <= gnt.alu1_g;
			fcu_q <= gnt.fcu_g;
			agen0_q <= gnt.agen0_g;
			agen1_q <= gnt.agen1_g;
			alu_issue_o <= gnt.alu_iss;
			fcu_issue_o <= gnt.fc_iss;
			agen_issue_o <= gnt.mem_iss;
			islot_o <= gnt.islot;
		end
	end

	// Grants leave as separate index and valid pairs
	assign alu0_ndx_o = alu0_q.ndx;
	assign alu0_v_o = alu0_q.v;
	assign alu1_ndx_o = alu1_q.ndx;
	assign alu1_v_o = alu1_q.v;
	assign fcu_ndx_o = fcu_q.ndx;
	assign fcu_v_o = fcu_q.v;
	assign agen0_ndx_o = agen0_q.ndx;
	assign agen0_v_o = agen0_q.v;
	assign agen1_ndx_o = agen1_q.ndx;
	assign agen1_v_o = agen1_q.v;

	// Anything issued last cycle, whatever its class
	assign gnt.issued_mask = alu_issue_o | fcu_issue_o | agen_issue_o;

endmodule

//--- verilog/sched_top.sv
// Top level of the issue scheduler
// Connects the readiness, arbitration and output stages through two interfaces
// Grants appear two clocks after a ROB change and one clock after an idle change

`include "sched_config.svh"

module sched_top (
	input logic clk,
	input logic rst,
	input logic alu0_idle_i,
	input logic alu1_idle_i,
	input logic fcu_idle_i,
	input logic agen0_idle_i,
	input logic agen1_idle_i,
	input sched_pkg::rob_ndx_t head_i,
	input sched_pkg::rob_entry_t [`SCHED_ROB_ENTRIES-1:0] rob_i,
	input sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_i,
	output sched_pkg::rob_ndx_t alu0_ndx_o,
	output logic alu0_v_o,
	output sched_pkg::rob_ndx_t alu1_ndx_o,
	output logic alu1_v_o,
	output sched_pkg::rob_ndx_t fcu_ndx_o,
	output logic fcu_v_o,
	output sched_pkg::rob_ndx_t agen0_ndx_o,
	output logic agen0_v_o,
	output sched_pkg::rob_ndx_t agen1_ndx_o,
	output logic agen1_v_o,
	output sched_pkg::rob_bitmask_t alu_issue_o,
	output sched_pkg::rob_bitmask_t fcu_issue_o,
	output sched_pkg::rob_bitmask_t agen_issue_o,
	output sched_pkg::islot_t [`SCHED_ROB_ENTRIES-1:0] islot_o
);

	sched_ready_if u_rdy_if ();
	sched_grant_if u_gnt_if ();

	// Registered readiness, one clock behind the ROB
	sched_decode u_decode (
		.clk    (clk),
		.rst    (rst),
		.rob_i  (rob_i),
		.head_i (head_i),
		.rdy    (u_rdy_if),
		.gnt    (u_gnt_if)
	);

	// Combinational pick against the current idle inputs
	sched_execute u_execute (
		.alu0_idle_i  (alu0_idle_i),
		.alu1_idle_i  (alu1_idle_i),
		.fcu_idle_i   (fcu_idle_i),
		.agen0_idle_i (agen0_idle_i),
		.agen1_idle_i (agen1_idle_i),
		.islot_i      (islot_i),
		.rdy          (u_rdy_if),
		.gnt          (u_gnt_if)
	);

	sched_result u_result (
		.clk          (clk),
		.rst          (rst),
		.gnt          (u_gnt_if),
		.alu0_ndx_o   (alu0_ndx_o),
		.alu0_v_o     (alu0_v_o),
		.alu1_ndx_o   (alu1_ndx_o),
		.alu1_v_o     (alu1_v_o),
		.fcu_ndx_o    (fcu_ndx_o),
		.fcu_v_o      (fcu_v_o),
		.agen0_ndx_o  (agen0_ndx_o),
		.agen0_v_o    (agen0_v_o),
		.agen1_ndx_o  (agen1_ndx_o),
		.agen1_v_o    (agen1_v_o),
		.alu_issue_o  (alu_issue_o),
		.fcu_issue_o  (fcu_issue_o),
		.agen_issue_o (agen_issue_o),
		.islot_o      (islot_o)
	);

endmodule
